// ==== Bender.yml ====
package:
  name: bch_decoder

sources:
  - include_dirs:
      - .
    files:
      - bch_pkg.sv
      - bch_decode_ctrl.sv
      - bch_syndrome.sv
      - bch_key_solver.sv
      - bch_chien.sv
      - bch_decoder.sv
  - target: test
    files:
      - tb_bch_decoder.sv

// ==== bch_chien.sv ====
`timescale 1ns/1ps

module bch_chien #(
	parameter int T = 2
) (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    search_start,
	input  bch_pkg::code_word_t     word,
	input  bch_pkg::gf_elem_t [T:0] sigma,
	input  logic [1:0]              sigma_degree,
	output bch_pkg::decode_result_t result,
	output logic                    search_done
);
	import bch_pkg::*;
	`include "gf_arith.svh"

	localparam int pos_w = $clog2(code_n);
	localparam int root_w = $clog2(code_n + 1);

	gf_elem_t [T:0]    term_q;
	gf_elem_t [T:0]    term_next;
	gf_elem_t          sum;
	code_word_t        corr_q;
	code_word_t        corr_next;
	logic [root_w-1:0] roots_q;
	logic [root_w-1:0] roots_next;
	logic [pos_w-1:0]  step;
	logic [pos_w-1:0]  pos;
	logic              busy;
	logic              hit;
	logic              fail;

	// Step k evaluates sigma at alpha^(k+1).
	// Term i picks up one more alpha^i per step.
	always_comb begin
		sum = '0;
		for (int i = 0; i <= T; i++) begin
			term_next[i] = gf_mul(term_q[i], gf_alpha_pow(i));
			sum = sum ^ term_next[i];
		end
	end

	// A root at alpha^k marks position 15 - k, so bit 14 comes first.
	assign hit = (sum == '0);
	assign pos = pos_w'(code_n - 1) - step;

	always_comb begin
		corr_next = corr_q;
		corr_next[pos] = corr_q[pos] ^ hit;
	end

	assign roots_next = roots_q + root_w'(hit);
	assign search_done = busy && (step == pos_w'(code_n - 1));
	assign fail = (roots_next != root_w'(sigma_degree));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			step <= '0;
		end else if (search_start) begin
			busy <= 1'b1;
			step <= '0;
		end else if (busy) begin
			step <= search_done ? '0 : step + 1'b1;
			busy <= !search_done;
		end
	end

	always_ff @(posedge clk) begin
		if (search_start) begin
			term_q <= sigma;
			corr_q <= word;
			roots_q <= '0;
		end else if (busy) begin
			term_q <= term_next;
			corr_q <= corr_next;
			roots_q <= roots_next;
		end
		// Failed words go out as received.
		if (search_done) begin
			result.word <= fail ? word : corr_next;
			result.err_count <= fail ? 2'b00 : roots_next[1:0];
			result.uncorrectable <= fail;
		end
	end

endmodule

// ==== bch_decode_ctrl.sv ====
`timescale 1ns/1ps

module bch_decode_ctrl (
	input  logic clk,
	input  logic rst_n,
	input  logic in_valid,
	input  logic out_ready,
	input  logic syn_done,
	input  logic solve_done,
	input  logic search_done,
	output logic in_ready,
	output logic out_valid,
	output logic capture,
	output logic syn_start,
	output logic solve_start,
	output logic search_start
);
	import bch_pkg::*;

	dec_state_t state;
	dec_state_t state_next;
	logic       init_done;

	// Holds off input for the first cycle after reset.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			init_done <= 1'b0;
		end else begin
			init_done <= 1'b1;
		end
	end

	// Only one word in flight.
	assign in_ready = (state == st_idle) && init_done;
	assign capture = in_valid && in_ready;
	// Syndromes start in the transfer cycle itself.
	assign syn_start = capture;
	// Result held until the sink takes it.
	assign out_valid = (state == st_done);

	always_comb begin
		state_next = state;
		case (state)
			st_idle: begin
				if (capture) begin
					state_next = st_syndrome;
				end
			end
			st_syndrome: begin
				if (syn_done) begin
					state_next = st_solve;
				end
			end
			st_solve: begin
				if (solve_done) begin
					state_next = st_search;
				end
			end
			st_search: begin
				if (search_done) begin
					state_next = st_done;
				end
			end
			st_done: begin
				if (out_ready) begin
					state_next = st_idle;
				end
			end
			default: begin
				state_next = st_idle;
			end
		endcase
	end

	// Next stage starts one cycle after the previous one ends.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
			solve_start <= 1'b0;
			search_start <= 1'b0;
		end else begin
			state <= state_next;
			solve_start <= (state == st_syndrome) && syn_done;
			search_start <= (state == st_solve) && solve_done;
		end
	end

endmodule

// ==== bch_decoder.sv ====
`timescale 1ns/1ps

module bch_decoder #(
	parameter int T = 2
) (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    in_valid,
	input  logic                    out_ready,
	input  bch_pkg::code_word_t     in_word,
	output logic                    in_ready,
	output logic                    out_valid,
	output bch_pkg::decode_result_t out_result
);
	import bch_pkg::*;

	// Stage handshakes.
	logic capture;
	logic syn_start;
	logic syn_done;
	logic solve_start;
	logic solve_done;
	logic search_start;
	logic search_done;

	// Data passed between stages.
	code_word_t         word;
	gf_elem_t [2*T-1:0] syndromes;
	gf_elem_t [T:0]     sigma;
	logic [1:0]         sigma_degree;

	bch_decode_ctrl ctrl_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.in_valid     (in_valid),
		.out_ready    (out_ready),
		.syn_done     (syn_done),
		.solve_done   (solve_done),
		.search_done  (search_done),
		.in_ready     (in_ready),
		.out_valid    (out_valid),
		.capture      (capture),
		.syn_start    (syn_start),
		.solve_start  (solve_start),
		.search_start (search_start)
	);

	bch_syndrome #(.T(T)) syndrome_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.capture   (capture),
		.syn_start (syn_start),
		.in_word   (in_word),
		.word      (word),
		.syndromes (syndromes),
		.syn_done  (syn_done)
	);

	bch_key_solver #(.T(T)) solver_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.solve_start  (solve_start),
		.syndromes    (syndromes),
		.sigma        (sigma),
		.sigma_degree (sigma_degree),
		.solve_done   (solve_done)
	);

	bch_chien #(.T(T)) chien_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.search_start (search_start),
		.word         (word),
		.sigma        (sigma),
		.sigma_degree (sigma_degree),
		.result       (out_result),
		.search_done  (search_done)
	);

endmodule

// ==== bch_key_solver.sv ====
`timescale 1ns/1ps

module bch_key_solver #(
	parameter int T = 2
) (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        solve_start,
	input  bch_pkg::gf_elem_t [2*T-1:0] syndromes,
	output bch_pkg::gf_elem_t [T:0]     sigma,
	output logic [1:0]                  sigma_degree,
	output logic                        solve_done
);
	import bch_pkg::*;
	`include "gf_arith.svh"

	// One spare coefficient above T shows a locator that grew too long.
	localparam int n_term = T + 2;
	localparam int iter_w = $clog2(T + 1);
	localparam int ph_w = $clog2(gf_m + 1);
	localparam int bit_w = $clog2(gf_m);
	localparam int len_w = $clog2(2 * T + 2);

	gf_elem_t [n_term-1:0] sig_q;
	gf_elem_t [n_term-1:0] beta_q;
	gf_elem_t [n_term-1:0] syn_sel;
	gf_elem_t              d_p;
	gf_elem_t              acc;
	gf_elem_t              partial;
	gf_elem_t              d_rp;
	logic [iter_w-1:0]     iter;
	logic [ph_w-1:0]       phase;
	logic [bit_w-1:0]      bit_idx;
	logic [len_w-1:0]      len;
	logic                  busy;
	logic                  last_phase;
	logic                  swap;

	// Iteration r pairs sigma_i with S(2r+1-i).
	// Indices outside 1..2T give zero.
	always_comb begin
		int k;
		for (int i = 0; i < n_term; i++) begin
			k = 2 * int'(iter) + 1 - i;
			if (k >= 1 && k <= 2 * T) begin
				syn_sel[i] = syndromes[k-1];
			end else begin
				syn_sel[i] = '0;
			end
		end
	end

	// One bit of every sigma term per cycle, MSB first.
	assign bit_idx = bit_w'(gf_m - 1 - int'(phase));

	always_comb begin
		partial = '0;
		for (int i = 0; i < n_term; i++) begin
			if (sig_q[i][bit_idx]) begin
				partial = partial ^ syn_sel[i];
			end
		end
	end

	assign last_phase = busy && (phase == ph_w'(gf_m));
	assign solve_done = last_phase && (iter == iter_w'(T - 1));

	// acc holds d_r in the update cycle.
	assign d_rp = gf_mul(acc, gf_inv(d_p));
	// Length change only when d_r is nonzero and 2L <= 2r.
	assign swap = (acc != '0) && (int'(len) <= int'(iter));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			iter <= '0;
			phase <= '0;
		end else if (solve_start) begin
			busy <= 1'b1;
			iter <= '0;
			phase <= '0;
		end else if (busy) begin
			if (last_phase) begin
				phase <= '0;
				iter <= iter + 1'b1;
				busy <= !solve_done;
			end else begin
				phase <= phase + 1'b1;
			end
		end
	end

	// Start from sigma = 1, beta = x, d_p = 1.
	// After the first pass sigma is 1 + S1 x and beta is x^2, or x^3 when S1 is zero.
	always_ff @(posedge clk) begin
		if (solve_start) begin
			for (int i = 0; i < n_term; i++) begin
				sig_q[i] <= (i == 0) ? gf_elem_t'(1) : '0;
				beta_q[i] <= (i == 1) ? gf_elem_t'(1) : '0;
			end
			d_p <= gf_elem_t'(1);
			len <= '0;
			acc <= '0;
		end else if (busy) begin
			if (!last_phase) begin
				// Horner over the bit planes gives sum of sigma_i * S.
				acc <= (phase == '0) ? partial : (gf_mul(acc, gf_alpha_pow(1)) ^ partial);
			end else begin
				for (int i = 0; i < n_term; i++) begin
					sig_q[i] <= sig_q[i] ^ gf_mul(d_rp, beta_q[i]);
				end
				// beta = x^2 times old sigma or old beta.
				beta_q[0] <= '0;
				beta_q[1] <= '0;
				for (int i = 2; i < n_term; i++) begin
					beta_q[i] <= swap ? sig_q[i-2] : beta_q[i-2];
				end
				if (swap) begin
					d_p <= acc;
					len <= len_w'(2 * int'(iter) + 1 - int'(len));
				end
			end
		end
	end

	assign sigma = sig_q[T:0];

	// Degree from the highest nonzero coefficient, spare term included.
	always_comb begin
		sigma_degree = '0;
		for (int i = 1; i < n_term; i++) begin
			if (sig_q[i] != '0) begin
				sigma_degree = 2'(i);
			end
		end
	end

endmodule

// ==== bch_pkg.sv ====
package bch_pkg;

	// Field width of GF(2^4).
	localparam int gf_m = 4;

	// Code length of the primitive code over GF(2^4).
	localparam int code_n = 15;

	// Primitive polynomial x^4 + x + 1 with the x^4 term left out.
	// Alpha is the element 4'b0010 in the polynomial basis.
	localparam logic [gf_m-1:0] gf_poly = 4'b0011;

	// One field element.
	// Bit k holds the coefficient of alpha^k.
	typedef logic [gf_m-1:0] gf_elem_t;

	// Received or corrected word.
	// Bit 14 is sent first and is the x^14 coefficient.
	typedef logic [code_n-1:0] code_word_t;

	// Decoder result as handed to the output side.
	typedef struct packed {
		// Corrected word, or the received word when decoding fails.
		code_word_t word;
		// Number of bits flipped.
		logic [1:0] err_count;
		// Root count of the locator does not match its degree.
		logic uncorrectable;
	} decode_result_t;

	// Controller states, one per decoder stage.
	typedef enum logic [2:0] {
		// Waiting for a word.
		st_idle,
		// Word shifts through the syndrome circuits.
		st_syndrome,
		// Key equation solver runs.
		st_solve,
		// Chien search walks the positions.
		st_search,
		// Result offered until taken.
		st_done
	} dec_state_t;

endpackage

// ==== bch_syndrome.sv ====
`timescale 1ns/1ps

module bch_syndrome #(
	parameter int T = 2
) (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        capture,
	input  logic                        syn_start,
	input  bch_pkg::code_word_t         in_word,
	output bch_pkg::code_word_t         word,
	output bch_pkg::gf_elem_t [2*T-1:0] syndromes,
	output logic                        syn_done
);
	import bch_pkg::*;
	`include "gf_arith.svh"

	localparam int cnt_w = $clog2(code_n);

	// Entry i holds S(2i+1).
	gf_elem_t [T-1:0]  syn_odd;
	logic [cnt_w-1:0]  bit_cnt;
	logic              busy;
	logic              rx_bit;

	// Received word, kept for the Chien search.
	always_ff @(posedge clk) begin
		if (capture) begin
			word <= in_word;
		end
	end

	// MSB first, so bit 14 goes in on the first busy cycle.
	assign rx_bit = word[cnt_w'(code_n - 1) - bit_cnt];
	assign syn_done = busy && (bit_cnt == cnt_w'(code_n - 1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			bit_cnt <= '0;
		end else if (syn_start) begin
			busy <= 1'b1;
			bit_cnt <= '0;
		end else if (busy) begin
			bit_cnt <= syn_done ? '0 : bit_cnt + 1'b1;
			busy <= !syn_done;
		end
	end

	// Horner step S = S * alpha^j + r for every odd j.
	always_ff @(posedge clk) begin
		for (int i = 0; i < T; i++) begin
			if (syn_start) begin
				syn_odd[i] <= '0;
			end else if (busy) begin
				syn_odd[i] <= gf_mul(syn_odd[i], gf_alpha_pow(2 * i + 1)) ^ gf_elem_t'(rx_bit);
			end
		end
	end

	// Binary code, so S(2k) is S(k) squared.
	for (genvar k = 1; k <= 2 * T; k++) begin : g_syn
		if (k % 2 == 1) begin : g_odd
			assign syndromes[k-1] = syn_odd[(k-1)/2];
		end else begin : g_even
			assign syndromes[k-1] = gf_mul(syndromes[k/2-1], syndromes[k/2-1]);
		end
	end

endmodule

// ==== bch_vectors.txt ====
// Columns (hex): received word, expected word, expected err_count, expected uncorrectable.
// Codewords are multiples of g(x) = x^8+x^7+x^6+x^4+1.
// No errors.
0000 0000 0 0
7fff 7fff 0 0
6fc5 6fc5 0 0
// One error, bit 14 down to bit 0.
4000 0000 1 0
5fff 7fff 1 0
6440 7440 1 0
67c5 6fc5 1 0
32db 36db 1 0
03d1 01d1 1 0
0373 0273 1 0
0080 0000 1 0
7fbf 7fff 1 0
7460 7440 1 0
6fd5 6fc5 1 0
36d3 36db 1 0
01d5 01d1 1 0
0271 0273 1 0
7ffe 7fff 1 0
// Two errors.
4001 0000 2 0
1fff 7fff 2 0
6dc1 6fc5 2 0
26fb 36db 2 0
7542 7440 2 0
0a7b 0273 2 0
// Three errors with S1 zero, beta starts at x^3.
0013 0013 0 1
33ff 33ff 0 1
6be4 6be4 0 1
3ef3 3ef3 0 1
// Three errors, no codeword within distance two.
01da 01da 0 1
74f0 74f0 0 1
5a73 5a73 0 1
// Three errors within distance two of another codeword.
6fc2 4dc2 2 0
7000 7440 2 0

// ==== compile.f ====
+incdir+.
bch_pkg.sv
bch_decode_ctrl.sv
bch_syndrome.sv
bch_key_solver.sv
bch_chien.sv
bch_decoder.sv
tb_bch_decoder.sv

// ==== gf_arith.svh ====
// Field arithmetic over GF(2^4) in the polynomial basis.
// Included inside a module body after bch_pkg has been imported.

// Product of two elements by shift and add.
function automatic gf_elem_t gf_mul(input gf_elem_t a, input gf_elem_t b);
	gf_elem_t acc;
	gf_elem_t sh;
	acc = '0;
	sh = a;
	for (int i = 0; i < gf_m; i++) begin
		if (b[i]) begin
			acc = acc ^ sh;
		end
		// Step to the next power of alpha and fold the x^4 term back.
		sh = sh[gf_m-1] ? ((sh << 1) ^ gf_poly) : (sh << 1);
	end
	return acc;
endfunction

// Inverse as a^(2^m - 2), built from the squares a^2, a^4, a^8.
// Zero comes out as zero.
function automatic gf_elem_t gf_inv(input gf_elem_t a);
	gf_elem_t sq;
	gf_elem_t acc;
	sq = a;
	acc = gf_elem_t'(1);
	for (int i = 1; i < gf_m; i++) begin
		sq = gf_mul(sq, sq);
		acc = gf_mul(acc, sq);
	end
	return acc;
endfunction

// Alpha raised to a constant power, taken modulo the group order.
function automatic gf_elem_t gf_alpha_pow(input int e);
	gf_elem_t acc;
	int e_red;
	acc = gf_elem_t'(1);
	e_red = e % code_n;
	for (int i = 0; i < code_n; i++) begin
		if (i < e_red) begin
			acc = gf_mul(acc, gf_elem_t'(2));
		end
	end
	return acc;
endfunction

// ==== tb_bch_decoder.sv ====
`timescale 1ns/1ps

module tb_bch_decoder;
	import bch_pkg::*;

	localparam int T = 2;
	localparam int reset_cycles = 16;
	localparam int max_vec = 64;
	// Syndrome pass, T solver iterations of m + 1 cycles, search pass.
	// One more cycle for each of the three stage hand-overs.
	localparam int latency = code_n + T * (gf_m + 1) + code_n + 3;
	// Per-word budget covers the latency plus room for back-pressure.
	localparam int cycles_per_vec = 60;

	logic           clk;
	logic           rst_n;
	logic           in_valid;
	logic           out_ready;
	code_word_t     in_word;
	logic           in_ready;
	logic           out_valid;
	decode_result_t out_result;

	// Each vector takes four entries holding received word, corrected word, err_count and flag.
	logic [15:0]    vec_mem [0:4*max_vec-1];
	int             num_vec;
	logic           vec_loaded;
	integer         seed;
	logic [31:0]    rnd;
	// Output side bookkeeping.
	int             taken;
	int             wait_cycles;
	logic           in_flight;
	logic           hold_valid;
	decode_result_t held;

	bch_decoder #(.T(T)) bch_decoder_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.out_ready  (out_ready),
		.in_word    (in_word),
		.in_ready   (in_ready),
		.out_valid  (out_valid),
		.out_result (out_result)
	);

	// 40 ns period.
	always #20 clk = ~clk;

	task automatic halt_with_failure();
		$display("=== FAIL ===");
		$fatal(1);
	endtask

	// Value check on one output field.
	task automatic check_field(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			$display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
			halt_with_failure();
		end
	endtask

	// Protocol check with a plain description.
	task automatic expect_true(input logic cond, input string what);
		assert (cond === 1'b1) else begin
			$display("ERROR: %s", what);
			halt_with_failure();
		end
	endtask

	// Random back-pressure, drawn every falling edge.
	always @(negedge clk) begin
		rnd = $random(seed);
		out_ready = rnd[0];
	end

	// Monitor samples at the rising edge, before any register moves.
	always @(posedge clk) begin
		if (rst_n) begin
			// An offered result holds until taken.
			if (hold_valid) begin
				expect_true(out_valid, "out_valid dropped before the result was taken");
				check_field("out_result", out_result, held);
			end
			expect_true(!(in_flight && in_ready), "in_ready high while a word is in flight");
			expect_true(!out_valid || in_flight, "out_valid high with no word in flight");
			// out_valid must first appear a fixed number of cycles after the transfer.
			if (in_flight) begin
				wait_cycles++;
				if (out_valid && !hold_valid) begin
					check_field("out_valid latency", wait_cycles, latency);
				end
			end
			if (out_valid && out_ready) begin
				// Results must come back in vector order.
				check_field("out_result.word", out_result.word, vec_mem[4*taken+1]);
				check_field("out_result.err_count", out_result.err_count,
					vec_mem[4*taken+2]);
				check_field("out_result.uncorrectable", out_result.uncorrectable,
					vec_mem[4*taken+3]);
				taken++;
				in_flight = 1'b0;
				hold_valid = 1'b0;
			end else if (out_valid) begin
				held = out_result;
				hold_valid = 1'b1;
			end
			if (in_valid && in_ready) begin
				wait_cycles = 0;
				in_flight = 1'b1;
			end
		end
	end

	// Watchdog sized from the vector count.
	initial begin
		wait (vec_loaded);
		repeat (num_vec * cycles_per_vec + reset_cycles) @(posedge clk);
		$display("ERROR: watchdog expired, decoder stopped making progress");
		halt_with_failure();
	end

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_word = '0;
		out_ready = 1'b0;
		seed = 32'h9ea3;
		taken = 0;
		wait_cycles = 0;
		in_flight = 1'b0;
		hold_valid = 1'b0;
		held = '0;
		num_vec = 0;
		vec_loaded = 1'b0;

		// Unused entries keep a marker that no 15-bit word can have.
		for (int i = 0; i < 4 * max_vec; i++) begin
			vec_mem[i] = 16'hffff;
		end
		$readmemh("bch_vectors.txt", vec_mem);
		while (num_vec < max_vec && vec_mem[4*num_vec] != 16'hffff) begin
			num_vec++;
		end
		vec_loaded = 1'b1;
		expect_true(num_vec > 0, "no test vectors were read");

		repeat (reset_cycles) @(negedge clk);
		expect_true(!out_valid && !in_ready, "handshake outputs active during reset");
		rst_n = 1'b1;
		// in_ready comes up one cycle after reset ends.
		@(negedge clk);
		expect_true(in_ready, "in_ready still low one cycle after reset");
		expect_true(!out_valid, "out_valid high before any word was sent");

		for (int v = 0; v < num_vec; v++) begin
			in_valid = 1'b1;
			in_word = vec_mem[4*v][code_n-1:0];
			// Word stays put until the decoder takes it.
			while (!in_ready) begin
				@(negedge clk);
			end
			@(negedge clk);
		end
		in_valid = 1'b0;
		in_word = '0;

		wait (taken == num_vec);
		@(negedge clk);
		expect_true(!out_valid, "extra result after the last vector");
		$display("=== PASS ===");
		$finish;
	end

endmodule
